// ==== src/wb_pkg.sv ====
package wb_pkg;

  // ==============================
  // Datapath widths
  // ==============================

  // Width of one general register or one CSR value
  localparam int data_width = 32;

  // Width of a general register number
  localparam int reg_addr_width = 5;

  // ==============================
  // Register file size
  // ==============================

  // Number of architectural general registers, r0 included
  localparam int reg_count = 32;

  // ==============================
  // Debug trace
  // ==============================

  // Byte write enable on the trace port, one bit per byte of data
  localparam int debug_we_width = 4;

endpackage

// ==== src/csr_pkg.sv ====
package csr_pkg;

  localparam int csr_num_width = 14;

  // ==============================
  // CSR numbers
  // ==============================
  localparam logic [csr_num_width-1:0] csr_crmd   = 14'h000;
  localparam logic [csr_num_width-1:0] csr_prmd   = 14'h001;
  localparam logic [csr_num_width-1:0] csr_estat  = 14'h005;
  localparam logic [csr_num_width-1:0] csr_era    = 14'h006;
  localparam logic [csr_num_width-1:0] csr_eentry = 14'h00c;
  localparam logic [csr_num_width-1:0] csr_save0  = 14'h030;
  localparam logic [csr_num_width-1:0] csr_save1  = 14'h031;
  localparam logic [csr_num_width-1:0] csr_save2  = 14'h032;
  localparam logic [csr_num_width-1:0] csr_save3  = 14'h033;

  // ==============================
  // Field positions
  // ==============================

  // PRMD keeps PPLV and PIE at the same places as CRMD keeps PLV and IE
  localparam int crmd_plv_lsb = 0;
  localparam int plv_width    = 2;
  localparam int crmd_ie_bit  = 2;

  localparam int estat_ecode_lsb    = 16;
  localparam int ecode_width        = 6;
  localparam int estat_esubcode_lsb = 22;
  localparam int esubcode_width     = 9;

  localparam logic [ecode_width-1:0] ecode_sys = 6'hb;

  // ==============================
  // Implemented writable bits
  // ==============================
  localparam logic [31:0] crmd_mask   = 32'h0000_0007;
  localparam logic [31:0] prmd_mask   = 32'h0000_0007;
  // ESTAT fields are only changed by hardware here
  localparam logic [31:0] estat_mask  = 32'h0000_0000;
  localparam logic [31:0] eentry_mask = 32'hffff_ffc0;

endpackage

// ==== src/wb_stage.sv ====
`timescale 1ns/10ps

module wb_stage (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              ms_valid,
  input  logic [wb_pkg::data_width-1:0]     ms_pc,
  input  logic                              ms_gr_we,
  input  logic [wb_pkg::reg_addr_width-1:0] ms_dest,
  input  logic [wb_pkg::data_width-1:0]     ms_result,
  input  logic                              ms_csr_re,
  input  logic                              ms_csr_we,
  input  logic [csr_pkg::csr_num_width-1:0] ms_csr_num,
  input  logic [wb_pkg::data_width-1:0]     ms_csr_wmask,
  input  logic [wb_pkg::data_width-1:0]     ms_csr_wvalue,
  input  logic                              ms_syscall,
  input  logic                              ms_ertn,
  output logic                              ws_allowin,
  output logic                              csr_re,
  output logic [csr_pkg::csr_num_width-1:0] csr_num,
  input  logic [wb_pkg::data_width-1:0]     csr_rvalue,
  output logic                              csr_we,
  output logic [wb_pkg::data_width-1:0]     csr_wmask,
  output logic [wb_pkg::data_width-1:0]     csr_wvalue,
  output logic                              wb_ex,
  output logic                              ertn_flush,
  output logic [wb_pkg::data_width-1:0]     ws_pc,
  output logic                              rf_we,
  output logic [wb_pkg::reg_addr_width-1:0] rf_waddr,
  output logic [wb_pkg::data_width-1:0]     rf_wdata,
  output logic [wb_pkg::data_width-1:0]     debug_wb_pc,
  output logic [wb_pkg::debug_we_width-1:0] debug_wb_rf_we,
  output logic [wb_pkg::reg_addr_width-1:0] debug_wb_rf_wnum,
  output logic [wb_pkg::data_width-1:0]     debug_wb_rf_wdata
);
  import wb_pkg::*;
  import csr_pkg::*;

  logic                      ws_valid;
  logic                      gr_we_r;
  logic                      csr_re_r;
  logic                      csr_we_r;
  logic                      syscall_r;
  logic                      ertn_r;
  logic [reg_addr_width-1:0] dest_r;
  logic [data_width-1:0]     result_r;
  logic [csr_num_width-1:0]  csr_num_r;
  logic [data_width-1:0]     csr_wmask_r;
  logic [data_width-1:0]     csr_wvalue_r;
  logic                      flush_cycle;
  logic                      accept;

  // ==============================
  // Handshake and stage register
  // ==============================

  // A retiring syscall or ertn holds off the next item for its one flush cycle
  assign flush_cycle = ws_valid && (syscall_r || ertn_r);
  assign ws_allowin  = !flush_cycle;
  assign accept      = ms_valid && ws_allowin;

  always_ff @(posedge clk) begin
    if (reset) begin
      ws_valid  <= 1'b0;
      gr_we_r   <= 1'b0;
      csr_re_r  <= 1'b0;
      csr_we_r  <= 1'b0;
      syscall_r <= 1'b0;
      ertn_r    <= 1'b0;
    end else begin
      if (wb_ex || ertn_flush) begin
        ws_valid <= 1'b0;
      end else if (ws_allowin) begin
        ws_valid <= ms_valid;
      end
      if (accept) begin
        gr_we_r   <= ms_gr_we;
        csr_re_r  <= ms_csr_re;
        csr_we_r  <= ms_csr_we;
        syscall_r <= ms_syscall;
        ertn_r    <= ms_ertn;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ws_pc        <= ms_pc;
      dest_r       <= ms_dest;
      result_r     <= ms_result;
      csr_num_r    <= ms_csr_num;
      csr_wmask_r  <= ms_csr_wmask;
      csr_wvalue_r <= ms_csr_wvalue;
    end
  end

  // ==============================
  // Retire strobes
  // ==============================
  assign wb_ex      = ws_valid && syscall_r;
  assign ertn_flush = ws_valid && ertn_r;
  assign csr_re     = ws_valid && csr_re_r;
  // Exception entry and return own the CSRs in their cycle
  assign csr_we     = ws_valid && csr_we_r && !syscall_r && !ertn_r;
  assign csr_num    = csr_num_r;
  assign csr_wmask  = csr_wmask_r;
  assign csr_wvalue = csr_wvalue_r;

  assign rf_we    = ws_valid && gr_we_r;
  assign rf_waddr = dest_r;
  assign rf_wdata = csr_re ? csr_rvalue : result_r;

  assign debug_wb_pc       = ws_pc;
  assign debug_wb_rf_we    = {debug_we_width{rf_we}};
  assign debug_wb_rf_wnum  = dest_r;
  assign debug_wb_rf_wdata = rf_wdata;

  a_one_flush_kind: assert property (@(posedge clk) disable iff (reset)
    ws_valid |-> !(syscall_r && ertn_r))
    else $error("syscall and ertn set on the same item");

  // An item held back by a flush stays on the inputs until it is taken
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    (ms_valid && !ws_allowin) |=> (ms_valid && $stable(ms_pc) && $stable(ms_dest)
      && $stable(ms_syscall) && $stable(ms_ertn)))
    else $error("held item changed while ws_allowin was low");

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/10ps

module csr_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              csr_re,
  input  logic [csr_pkg::csr_num_width-1:0] csr_num,
  output logic [wb_pkg::data_width-1:0]     csr_rvalue,
  input  logic                              csr_we,
  input  logic [wb_pkg::data_width-1:0]     csr_wmask,
  input  logic [wb_pkg::data_width-1:0]     csr_wvalue,
  input  logic                              wb_ex,
  input  logic                              ertn_flush,
  input  logic [wb_pkg::data_width-1:0]     ws_pc,
  output logic                              flush,
  output logic [wb_pkg::data_width-1:0]     flush_target
);
  import wb_pkg::*;
  import csr_pkg::*;

  logic [data_width-1:0] crmd;
  logic [data_width-1:0] prmd;
  logic [data_width-1:0] estat;
  logic [data_width-1:0] era;
  logic [data_width-1:0] eentry;
  logic [data_width-1:0] save0;
  logic [data_width-1:0] save1;
  logic [data_width-1:0] save2;
  logic [data_width-1:0] save3;
  logic [data_width-1:0] read_value;

  // Only bits that are both requested and implemented take the new value
  function automatic logic [data_width-1:0] masked_write(
    input logic [data_width-1:0] old_value,
    input logic [data_width-1:0] new_value,
    input logic [data_width-1:0] wmask,
    input logic [data_width-1:0] impl
  );
    logic [data_width-1:0] sel;
    sel = wmask & impl;
    return (old_value & ~sel) | (new_value & sel);
  endfunction

  // ==============================
  // Read port
  // ==============================
  always_comb begin
    case (csr_num)
      csr_crmd:   read_value = crmd;
      csr_prmd:   read_value = prmd;
      csr_estat:  read_value = estat;
      csr_era:    read_value = era;
      csr_eentry: read_value = eentry;
      csr_save0:  read_value = save0;
      csr_save1:  read_value = save1;
      csr_save2:  read_value = save2;
      csr_save3:  read_value = save3;
      default:    read_value = '0;
    endcase
  end

  assign csr_rvalue = csr_re ? read_value : '0;

  // ==============================
  // Update
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      crmd   <= '0;
      prmd   <= '0;
      estat  <= '0;
      era    <= '0;
      eentry <= '0;
      save0  <= '0;
      save1  <= '0;
      save2  <= '0;
      save3  <= '0;
    end else if (wb_ex) begin
      prmd[crmd_plv_lsb +: plv_width]          <= crmd[crmd_plv_lsb +: plv_width];
      prmd[crmd_ie_bit]                        <= crmd[crmd_ie_bit];
      crmd[crmd_plv_lsb +: plv_width]          <= '0;
      crmd[crmd_ie_bit]                        <= 1'b0;
      estat[estat_ecode_lsb +: ecode_width]    <= ecode_sys;
      estat[estat_esubcode_lsb +: esubcode_width] <= '0;
      era                                      <= ws_pc;
    end else if (ertn_flush) begin
      crmd[crmd_plv_lsb +: plv_width] <= prmd[crmd_plv_lsb +: plv_width];
      crmd[crmd_ie_bit]               <= prmd[crmd_ie_bit];
    end else if (csr_we) begin
      case (csr_num)
        csr_crmd:   crmd   <= masked_write(crmd, csr_wvalue, csr_wmask, crmd_mask);
        csr_prmd:   prmd   <= masked_write(prmd, csr_wvalue, csr_wmask, prmd_mask);
        csr_estat:  estat  <= masked_write(estat, csr_wvalue, csr_wmask, estat_mask);
        csr_era:    era    <= masked_write(era, csr_wvalue, csr_wmask, '1);
        csr_eentry: eentry <= masked_write(eentry, csr_wvalue, csr_wmask, eentry_mask);
        csr_save0:  save0  <= masked_write(save0, csr_wvalue, csr_wmask, '1);
        csr_save1:  save1  <= masked_write(save1, csr_wvalue, csr_wmask, '1);
        csr_save2:  save2  <= masked_write(save2, csr_wvalue, csr_wmask, '1);
        csr_save3:  save3  <= masked_write(save3, csr_wvalue, csr_wmask, '1);
        default: ;
      endcase
    end
  end

  // Fetch is redirected in the same cycle the flushing instruction retires
  assign flush = wb_ex || ertn_flush;

  always_comb begin
    if (wb_ex) begin
      flush_target = eentry;
    end else if (ertn_flush) begin
      flush_target = era;
    end else begin
      flush_target = '0;
    end
  end

  // The stage must drop the software write of a syscall
  a_no_write_on_ex: assert property (@(posedge clk) disable iff (reset)
    wb_ex |-> !csr_we)
    else $error("CSR write strobe during exception entry");

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              rf_we,
  input  logic [wb_pkg::reg_addr_width-1:0] rf_waddr,
  input  logic [wb_pkg::data_width-1:0]     rf_wdata,
  input  logic [wb_pkg::reg_addr_width-1:0] rd_addr1,
  output logic [wb_pkg::data_width-1:0]     rd_data1,
  input  logic [wb_pkg::reg_addr_width-1:0] rd_addr2,
  output logic [wb_pkg::data_width-1:0]     rd_data2
);
  import wb_pkg::*;

  logic [data_width-1:0] regs [reg_count];

  // ==============================
  // Write port
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // Reads bypass nothing, so a same-cycle write shows up one cycle later
  assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
  assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

// ==== src/retire_unit.sv ====
`timescale 1ns/10ps

module retire_unit (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              ms_valid,
  input  logic [wb_pkg::data_width-1:0]     ms_pc,
  input  logic                              ms_gr_we,
  input  logic [wb_pkg::reg_addr_width-1:0] ms_dest,
  input  logic [wb_pkg::data_width-1:0]     ms_result,
  input  logic                              ms_csr_re,
  input  logic                              ms_csr_we,
  input  logic [csr_pkg::csr_num_width-1:0] ms_csr_num,
  input  logic [wb_pkg::data_width-1:0]     ms_csr_wmask,
  input  logic [wb_pkg::data_width-1:0]     ms_csr_wvalue,
  input  logic                              ms_syscall,
  input  logic                              ms_ertn,
  output logic                              ws_allowin,
  input  logic [wb_pkg::reg_addr_width-1:0] rd_addr1,
  output logic [wb_pkg::data_width-1:0]     rd_data1,
  input  logic [wb_pkg::reg_addr_width-1:0] rd_addr2,
  output logic [wb_pkg::data_width-1:0]     rd_data2,
  output logic                              flush,
  output logic [wb_pkg::data_width-1:0]     flush_target,
  output logic [wb_pkg::data_width-1:0]     debug_wb_pc,
  output logic [wb_pkg::debug_we_width-1:0] debug_wb_rf_we,
  output logic [wb_pkg::reg_addr_width-1:0] debug_wb_rf_wnum,
  output logic [wb_pkg::data_width-1:0]     debug_wb_rf_wdata
);
  import wb_pkg::*;
  import csr_pkg::*;

  logic                      csr_re;
  logic [csr_num_width-1:0]  csr_num;
  logic [data_width-1:0]     csr_rvalue;
  logic                      csr_we;
  logic [data_width-1:0]     csr_wmask;
  logic [data_width-1:0]     csr_wvalue;
  logic                      wb_ex;
  logic                      ertn_flush;
  logic [data_width-1:0]     ws_pc;
  logic                      rf_we;
  logic [reg_addr_width-1:0] rf_waddr;
  logic [data_width-1:0]     rf_wdata;

  // ==============================
  // Writeback stage
  // ==============================
  wb_stage wb_stage_inst (
    .clk               (clk),
    .reset             (reset),
    .ms_valid          (ms_valid),
    .ms_pc             (ms_pc),
    .ms_gr_we          (ms_gr_we),
    .ms_dest           (ms_dest),
    .ms_result         (ms_result),
    .ms_csr_re         (ms_csr_re),
    .ms_csr_we         (ms_csr_we),
    .ms_csr_num        (ms_csr_num),
    .ms_csr_wmask      (ms_csr_wmask),
    .ms_csr_wvalue     (ms_csr_wvalue),
    .ms_syscall        (ms_syscall),
    .ms_ertn           (ms_ertn),
    .ws_allowin        (ws_allowin),
    .csr_re            (csr_re),
    .csr_num           (csr_num),
    .csr_rvalue        (csr_rvalue),
    .csr_we            (csr_we),
    .csr_wmask         (csr_wmask),
    .csr_wvalue        (csr_wvalue),
    .wb_ex             (wb_ex),
    .ertn_flush        (ertn_flush),
    .ws_pc             (ws_pc),
    .rf_we             (rf_we),
    .rf_waddr          (rf_waddr),
    .rf_wdata          (rf_wdata),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_we    (debug_wb_rf_we),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata)
  );

  // ==============================
  // State owned by the stage
  // ==============================
  csr_file csr_file_inst (
    .clk          (clk),
    .reset        (reset),
    .csr_re       (csr_re),
    .csr_num      (csr_num),
    .csr_rvalue   (csr_rvalue),
    .csr_we       (csr_we),
    .csr_wmask    (csr_wmask),
    .csr_wvalue   (csr_wvalue),
    .wb_ex        (wb_ex),
    .ertn_flush   (ertn_flush),
    .ws_pc        (ws_pc),
    .flush        (flush),
    .flush_target (flush_target)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .reset    (reset),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata),
    .rd_addr1 (rd_addr1),
    .rd_data1 (rd_data1),
    .rd_addr2 (rd_addr2),
    .rd_data2 (rd_data2)
  );

endmodule

// ==== bench/retire_clock.sv ====
`timescale 1ns/10ps

module retire_clock (
  output logic clk
);

  // Half of the 40 ns period
  initial begin
    clk = 1'b0;
  end

  always begin
    #20 clk = ~clk;
  end

endmodule

// ==== bench/retire_tb.sv ====
`timescale 1ns/10ps

module retire_tb;
  import wb_pkg::*;
  import csr_pkg::*;

  logic                      clk;
  logic                      reset;
  logic                      ms_valid;
  logic [data_width-1:0]     ms_pc;
  logic                      ms_gr_we;
  logic [reg_addr_width-1:0] ms_dest;
  logic [data_width-1:0]     ms_result;
  logic                      ms_csr_re;
  logic                      ms_csr_we;
  logic [csr_num_width-1:0]  ms_csr_num;
  logic [data_width-1:0]     ms_csr_wmask;
  logic [data_width-1:0]     ms_csr_wvalue;
  logic                      ms_syscall;
  logic                      ms_ertn;
  logic                      ws_allowin;
  logic [reg_addr_width-1:0] rd_addr1;
  logic [data_width-1:0]     rd_data1;
  logic [reg_addr_width-1:0] rd_addr2;
  logic [data_width-1:0]     rd_data2;
  logic                      flush;
  logic [data_width-1:0]     flush_target;
  logic [data_width-1:0]     debug_wb_pc;
  logic [debug_we_width-1:0] debug_wb_rf_we;
  logic [reg_addr_width-1:0] debug_wb_rf_wnum;
  logic [data_width-1:0]     debug_wb_rf_wdata;

  // ==============================
  // Model state
  // ==============================
  logic [data_width-1:0]     model_regs [reg_count];
  logic [data_width-1:0]     m_crmd;
  logic [data_width-1:0]     m_prmd;
  logic [data_width-1:0]     m_estat;
  logic [data_width-1:0]     m_era;
  logic [data_width-1:0]     m_eentry;
  logic [data_width-1:0]     m_save0;
  logic [data_width-1:0]     m_save1;
  logic [data_width-1:0]     m_save2;
  logic [data_width-1:0]     m_save3;

  // The item the model expects in the writeback stage
  logic                      held_valid;
  logic [data_width-1:0]     held_pc;
  logic                      held_gr_we;
  logic [reg_addr_width-1:0] held_dest;
  logic [data_width-1:0]     held_result;
  logic                      held_csr_re;
  logic                      held_csr_we;
  logic [csr_num_width-1:0]  held_csr_num;
  logic [data_width-1:0]     held_csr_wmask;
  logic [data_width-1:0]     held_csr_wvalue;
  logic                      held_syscall;
  logic                      held_ertn;
  logic                      offer_held;

  logic [data_width-1:0]     next_pc;
  int item_count;
  int cycle_limit;
  int cycles;
  int issued;
  int retired;
  int syscalls;
  int ertns;
  int flush_stalls;
  int mismatches;
  int failures;

  retire_clock retire_clock_inst (.clk(clk));

  retire_unit retire_unit_inst (.*);

  task automatic flag_mismatch(input string what);
    $display("mismatch at %0t: %s", $time, what);
    mismatches++;
  endtask

  function automatic logic [data_width-1:0] model_csr_read(input logic [csr_num_width-1:0] num);
    case (num)
      csr_crmd:   return m_crmd;
      csr_prmd:   return m_prmd;
      csr_estat:  return m_estat;
      csr_era:    return m_era;
      csr_eentry: return m_eentry;
      csr_save0:  return m_save0;
      csr_save1:  return m_save1;
      csr_save2:  return m_save2;
      csr_save3:  return m_save3;
      default:    return '0;
    endcase
  endfunction

  // Bit by bit, a writable bit takes the new value
  function automatic logic [data_width-1:0] merge_bits(
    input logic [data_width-1:0] old_value,
    input logic [data_width-1:0] new_value,
    input logic [data_width-1:0] writable
  );
    logic [data_width-1:0] merged;
    merged = old_value;
    for (int b = 0; b < data_width; b++) begin
      if (writable[b]) begin
        merged[b] = new_value[b];
      end
    end
    return merged;
  endfunction

  task automatic model_csr_write(
    input logic [csr_num_width-1:0] num,
    input logic [data_width-1:0]    wmask,
    input logic [data_width-1:0]    wvalue
  );
    case (num)
      csr_crmd:   m_crmd   = merge_bits(m_crmd, wvalue, wmask & crmd_mask);
      csr_prmd:   m_prmd   = merge_bits(m_prmd, wvalue, wmask & prmd_mask);
      csr_estat:  m_estat  = merge_bits(m_estat, wvalue, wmask & estat_mask);
      csr_era:    m_era    = merge_bits(m_era, wvalue, wmask);
      csr_eentry: m_eentry = merge_bits(m_eentry, wvalue, wmask & eentry_mask);
      csr_save0:  m_save0  = merge_bits(m_save0, wvalue, wmask);
      csr_save1:  m_save1  = merge_bits(m_save1, wvalue, wmask);
      csr_save2:  m_save2  = merge_bits(m_save2, wvalue, wmask);
      csr_save3:  m_save3  = merge_bits(m_save3, wvalue, wmask);
      default: ;
    endcase
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic make_item();
    int kind;
    int pick;
    kind          = $urandom_range(99);
    pick          = $urandom_range(10);
    ms_valid      = 1'b1;
    ms_pc         = next_pc;
    ms_dest       = reg_addr_width'($urandom_range(31));
    ms_result     = $urandom;
    ms_csr_wvalue = $urandom;
    ms_csr_wmask  = ($urandom_range(2) == 0) ? 32'hffff_ffff : $urandom;
    ms_gr_we      = 1'b0;
    ms_csr_re     = 1'b0;
    ms_csr_we     = 1'b0;
    ms_syscall    = 1'b0;
    ms_ertn       = 1'b0;
    case (pick)
      0: ms_csr_num = csr_crmd;
      1: ms_csr_num = csr_prmd;
      2: ms_csr_num = csr_estat;
      3: ms_csr_num = csr_era;
      4: ms_csr_num = csr_eentry;
      5: ms_csr_num = csr_save0;
      6: ms_csr_num = csr_save1;
      7: ms_csr_num = csr_save2;
      8: ms_csr_num = csr_save3;
      default: ms_csr_num = csr_num_width'($urandom_range(16383));
    endcase
    if (kind < 50) begin
      ms_gr_we = 1'b1;
    end else if (kind < 82) begin
      // A CSR access returns the old CSR value to its destination
      ms_gr_we  = 1'b1;
      ms_csr_re = 1'b1;
      ms_csr_we = 1'($urandom_range(1));
    end else if (kind < 91) begin
      ms_syscall = 1'b1;
      ms_csr_we  = 1'($urandom_range(1));
    end else begin
      ms_ertn = 1'b1;
    end
    next_pc = next_pc + 32'd4;
  endtask

  task automatic offer_next();
    if (issued < item_count && $urandom_range(3) != 0) begin
      make_item();
      issued++;
    end else begin
      ms_valid  = 1'b0;
      ms_result = $urandom;
    end
  endtask

  // ==============================
  // Checks and model update
  // ==============================
  task automatic check_read_ports();
    if (rd_data1 !== model_regs[rd_addr1]) begin
      flag_mismatch($sformatf("rd_data1 r%0d expected %h got %h",
                              rd_addr1, model_regs[rd_addr1], rd_data1));
    end
    if (rd_data2 !== model_regs[rd_addr2]) begin
      flag_mismatch($sformatf("rd_data2 r%0d expected %h got %h",
                              rd_addr2, model_regs[rd_addr2], rd_data2));
    end
  endtask

  task automatic retire_held();
    logic [data_width-1:0] wdata;
    wdata = held_csr_re ? model_csr_read(held_csr_num) : held_result;
    if (held_gr_we && held_dest != '0) begin
      model_regs[held_dest] = wdata;
    end
    if (held_syscall) begin
      m_prmd[crmd_plv_lsb +: plv_width]            = m_crmd[crmd_plv_lsb +: plv_width];
      m_prmd[crmd_ie_bit]                          = m_crmd[crmd_ie_bit];
      m_crmd[crmd_plv_lsb +: plv_width]            = '0;
      m_crmd[crmd_ie_bit]                          = 1'b0;
      m_estat[estat_ecode_lsb +: ecode_width]       = ecode_sys;
      m_estat[estat_esubcode_lsb +: esubcode_width] = '0;
      m_era                                        = held_pc;
      syscalls++;
    end else if (held_ertn) begin
      m_crmd[crmd_plv_lsb +: plv_width] = m_prmd[crmd_plv_lsb +: plv_width];
      m_crmd[crmd_ie_bit]               = m_prmd[crmd_ie_bit];
      ertns++;
    end else if (held_csr_we) begin
      model_csr_write(held_csr_num, held_csr_wmask, held_csr_wvalue);
    end
    retired++;
  endtask

  task automatic step_cycle();
    logic                  exp_flush;
    logic                  exp_allowin;
    logic [data_width-1:0] exp_target;
    logic [data_width-1:0] exp_wdata;
    check_read_ports();
    exp_flush   = held_valid && (held_syscall || held_ertn);
    exp_allowin = !exp_flush;
    exp_target  = held_syscall ? m_eentry : m_era;
    if (ws_allowin !== exp_allowin) begin
      flag_mismatch($sformatf("ws_allowin expected %b got %b", exp_allowin, ws_allowin));
    end
    if (flush !== exp_flush) begin
      flag_mismatch($sformatf("flush expected %b got %b", exp_flush, flush));
    end
    if (exp_flush && flush_target !== exp_target) begin
      flag_mismatch($sformatf("flush_target expected %h got %h", exp_target, flush_target));
    end
    if (held_valid && debug_wb_pc !== held_pc) begin
      flag_mismatch($sformatf("debug_wb_pc expected %h got %h", held_pc, debug_wb_pc));
    end
    if (held_valid && held_gr_we) begin
      exp_wdata = held_csr_re ? model_csr_read(held_csr_num) : held_result;
      if (debug_wb_rf_we !== '1) begin
        flag_mismatch($sformatf("debug_wb_rf_we expected all ones got %h", debug_wb_rf_we));
      end
      if (debug_wb_rf_wnum !== held_dest) begin
        flag_mismatch($sformatf("debug_wb_rf_wnum expected %0d got %0d",
                                held_dest, debug_wb_rf_wnum));
      end
      if (debug_wb_rf_wdata !== exp_wdata) begin
        flag_mismatch($sformatf("debug_wb_rf_wdata pc %h expected %h got %h",
                                held_pc, exp_wdata, debug_wb_rf_wdata));
      end
    end else if (debug_wb_rf_we !== '0) begin
      flag_mismatch($sformatf("debug_wb_rf_we expected 0 got %h", debug_wb_rf_we));
    end
    if (held_valid) begin
      retire_held();
    end
    // An offer held back by a flush stays on the inputs for one more cycle
    if (!offer_held) begin
      offer_next();
    end
    // The offer moves into the stage at the next edge unless a flush holds it back
    held_valid = ms_valid && exp_allowin;
    offer_held = ms_valid && !exp_allowin;
    if (offer_held) begin
      flush_stalls++;
    end
    if (held_valid) begin
      held_pc         = ms_pc;
      held_gr_we      = ms_gr_we;
      held_dest       = ms_dest;
      held_result     = ms_result;
      held_csr_re     = ms_csr_re;
      held_csr_we     = ms_csr_we;
      held_csr_num    = ms_csr_num;
      held_csr_wmask  = ms_csr_wmask;
      held_csr_wvalue = ms_csr_wvalue;
      held_syscall    = ms_syscall;
      held_ertn       = ms_ertn;
    end
    rd_addr1 = ($urandom_range(7) == 0) ? '0 : reg_addr_width'($urandom_range(31));
    rd_addr2 = held_dest;
  endtask

  // ==============================
  // Run control
  // ==============================
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("error: run timed out after %0d cycles with %0d of %0d items retired",
               cycles, retired, item_count);
      failures++;
      $display("summary: %0d mismatches, %0d other failures", mismatches, failures);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc033));
    item_count   = 2000;
    cycle_limit  = item_count * 5;
    cycles       = 0;
    issued       = 0;
    retired      = 0;
    syscalls     = 0;
    ertns        = 0;
    flush_stalls = 0;
    mismatches   = 0;
    failures     = 0;
    next_pc      = 32'h1c00_0000;
    reset         = 1'b1;
    ms_valid      = 1'b0;
    ms_pc         = '0;
    ms_gr_we      = 1'b0;
    ms_dest       = '0;
    ms_result     = '0;
    ms_csr_re     = 1'b0;
    ms_csr_we     = 1'b0;
    ms_csr_num    = '0;
    ms_csr_wmask  = '0;
    ms_csr_wvalue = '0;
    ms_syscall    = 1'b0;
    ms_ertn       = 1'b0;
    rd_addr1      = '0;
    rd_addr2      = '0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    m_crmd     = '0;
    m_prmd     = '0;
    m_estat    = '0;
    m_era      = '0;
    m_eentry   = '0;
    m_save0    = '0;
    m_save1    = '0;
    m_save2    = '0;
    m_save3    = '0;
    held_valid = 1'b0;
    held_dest  = '0;
    offer_held = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    if (flush !== 1'b0 || debug_wb_rf_we !== '0) begin
      $display("error: flush or the trace write enable is not low after reset");
      failures++;
    end
    step_cycle();
    while (retired < item_count) begin
      @(negedge clk);
      step_cycle();
    end
    if (flush_stalls == 0 || syscalls == 0 || ertns == 0) begin
      $display("error: the run never held an item back behind a flush");
      failures++;
    end
    $write("summary: %0d retired, %0d syscall, %0d ertn, %0d stalls, ",
           retired, syscalls, ertns, flush_stalls);
    $display("%0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/wb_pkg.sv
src/csr_pkg.sv
src/wb_stage.sv
src/csr_file.sv
src/reg_file.sv
src/retire_unit.sv
bench/retire_clock.sv
bench/retire_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, then search the log for the failure line
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module retire_tb \
  && ./obj_dir/Vretire_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation reported failures"; exit 1; } \
  || { echo "simulation clean"; exit 0; }
